// File: include/irq_consts.svh
/*
 * Interrupt and sleep unit constants: request line count,
 * implemented line mask, interrupt id width and WFI sleep delay
 */
`ifndef IRQ_CONSTS_SVH
`define IRQ_CONSTS_SVH

// Number of interrupt request lines
`define IRQ_NUM 32

// Implemented lines are 31..16, 11, 7 and 3
`define IRQ_VALID_MASK 32'hffff_0888

// Width of an interrupt id
`define IRQ_ID_W 5

// Cycles from WFI strobe to the earliest core sleep
`define WFI_SLEEP_DELAY 2
`define SLP_CNT_W 2

`endif

// File: logic/irq_pkg.sv
/*
 * Interrupt types: privilege level, pending vectors passed
 * from the sampler and the registered arbitration result
 */
package irq_pkg;

  `include "irq_consts.svh"

  // Privilege level, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // Registered requests and the subset that is enabled in mie
  typedef struct packed {
    logic [`IRQ_NUM-1:0] mip;
    logic [`IRQ_NUM-1:0] pend_en;
  } irq_pend_t;

  // Winning interrupt of the arbiter
  typedef struct packed {
    logic                 valid;
    logic [`IRQ_ID_W-1:0] id;
  } irq_req_t;

endpackage

// File: logic/sleep_pkg.sv
/*
 * Sleep types: WFI state encoding and the wake-cause vector
 */
package sleep_pkg;

  typedef enum logic [1:0] {
    SLP_RUN   = 2'b00,
    SLP_WAIT  = 2'b01,
    SLP_SLEEP = 2'b10
  } sleep_state_e;

  // One bit per source that can end a WFI
  typedef struct packed {
    logic irq;
    logic debug;
    logic nmi;
  } wake_cause_t;

endpackage

// File: logic/irq_sampler.sv
/*
 * Interrupt sampler, first stage
 * Registers the request lines into mip, drops reserved lines
 * and forms the pending-and-enabled vector
 */
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_sampler (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [`IRQ_NUM-1:0] irq_i,
  input  logic [`IRQ_NUM-1:0] mie_i,
  output irq_pkg::irq_pend_t  pend_o
);

  localparam logic [`IRQ_NUM-1:0] valid_mask = `IRQ_VALID_MASK;

  logic [`IRQ_NUM-1:0] mip_q;

  // Reserved lines never reach the pending register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & valid_mask;
    end
  end

  // mie is applied live, not registered
  assign pend_o.mip     = mip_q;
  assign pend_o.pend_en = mip_q & mie_i;

  a_mip_not_reserved: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pend_o.mip & ~valid_mask) == '0
  ) else $error("mip has a reserved line set: %h", pend_o.mip);

endmodule

// File: logic/irq_arbiter.sv
/*
 * Interrupt arbiter, second stage
 * Fixed priority over the implemented lines: 31 down to 16,
 * then 11, 3 and 7. The winner is registered
 */
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::irq_pend_t pend_i,
  output irq_pkg::irq_req_t  req_o
);

  import irq_pkg::*;

  localparam logic [`IRQ_NUM-1:0]  valid_mask = `IRQ_VALID_MASK;

  // Standard machine interrupt ids
  localparam logic [`IRQ_ID_W-1:0] id_mei = 11;
  localparam logic [`IRQ_ID_W-1:0] id_msi = 3;
  localparam logic [`IRQ_ID_W-1:0] id_mti = 7;

  irq_req_t req_d;
  irq_req_t req_q;

  // ------------------------------------------------------------------
  // Priority encoder
  // ------------------------------------------------------------------
  // Lowest priority is assigned first, later matches override
  always_comb begin
    req_d = '0;
    if (pend_i.pend_en[id_mti]) begin
      req_d.valid = 1'b1;
      req_d.id    = id_mti;
    end
    if (pend_i.pend_en[id_msi]) begin
      req_d.valid = 1'b1;
      req_d.id    = id_msi;
    end
    if (pend_i.pend_en[id_mei]) begin
      req_d.valid = 1'b1;
      req_d.id    = id_mei;
    end
    // Platform lines, highest index wins
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_i.pend_en[i]) begin
        req_d.valid = 1'b1;
        req_d.id    = i[`IRQ_ID_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= '0;
    end else begin
      req_q <= req_d;
    end
  end

  assign req_o = req_q;

  a_id_implemented: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_o.valid |-> valid_mask[req_o.id]
  ) else $error("Arbiter selected reserved id %0d", req_o.id);

endmodule

// File: logic/irq_issue.sv
/*
 * Interrupt issue, third stage
 * Applies the global enable for the current privilege level
 * and emits a one-cycle acknowledge with the winning id
 */
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_issue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  irq_pkg::irq_req_t    req_i,
  input  logic                 mstatus_mie_i,
  input  irq_pkg::priv_lvl_e   priv_lvl_i,
  output logic                 irq_ack_o,
  output logic [`IRQ_ID_W-1:0] irq_id_o
);

  import irq_pkg::*;

  logic glob_en;
  logic ack_d;

  // U mode is always interruptible by machine interrupts
  assign glob_en = ((priv_lvl_i == PRIV_M) && mstatus_mie_i) || (priv_lvl_i == PRIV_U);

  // No ack two cycles in a row, a held request alternates
  assign ack_d = req_i.valid && glob_en && !irq_ack_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_o <= 1'b0;
    end else begin
      irq_ack_o <= ack_d;
    end
  end

  always_ff @(posedge clk_i) begin
    irq_id_o <= req_i.id;
  end

  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o
  ) else $error("irq_ack_o held for more than one cycle");

  a_ack_mmode_mie: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o && $past(priv_lvl_i == PRIV_M) |-> $past(mstatus_mie_i)
  ) else $error("Acknowledge in M mode with mstatus.mie clear");

endmodule

// File: logic/sleep_ctrl.sv
/*
 * WFI sleep controller
 * Enters WAIT on a WFI strobe, raises core sleep after the fixed
 * delay once the bus has been idle for two cycles, and wakes on
 * an enabled pending interrupt, a debug request or an NMI
 */
`timescale 1ns/1ps
`include "irq_consts.svh"

module sleep_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::irq_pend_t pend_i,
  input  logic               wfi_i,
  input  logic               bus_idle_i,
  input  logic               debug_req_i,
  input  logic               nmi_i,
  output logic               core_sleep_o
);

  import sleep_pkg::*;

  localparam logic [`SLP_CNT_W-1:0] delay = `WFI_SLEEP_DELAY;

  sleep_state_e         state_q, state_d;
  logic [`SLP_CNT_W-1:0] cnt_q, cnt_d;
  logic                 bus_idle_q;
  logic                 sleep_q, sleep_d;
  wake_cause_t          wake;
  logic                 wake_any;
  logic                 idle_ok;
  logic                 delay_done;

  assign wake.irq   = |pend_i.pend_en;
  assign wake.debug = debug_req_i;
  assign wake.nmi   = nmi_i;
  assign wake_any   = |wake;

  // Bus must be idle in this cycle and the one before
  assign idle_ok    = bus_idle_i && bus_idle_q;
  assign delay_done = (cnt_q + 1'b1 >= delay);

  // ------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    sleep_d = sleep_q;
    case (state_q)
      SLP_RUN: begin
        // A WFI with a wake cause already present is a no-op
        if (wfi_i && !wake_any) begin
          state_d = SLP_WAIT;
          cnt_d   = '0;
        end
      end
      SLP_WAIT: begin
        if (wake_any) begin
          state_d = SLP_RUN;
        end else if (delay_done && idle_ok) begin
          state_d = SLP_SLEEP;
          sleep_d = 1'b1;
        end else if (cnt_q != delay) begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      SLP_SLEEP: begin
        if (wake_any) begin
          state_d = SLP_RUN;
          sleep_d = 1'b0;
        end
      end
      default: begin
        state_d = SLP_RUN;
        sleep_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SLP_RUN;
      cnt_q      <= '0;
      bus_idle_q <= 1'b0;
      sleep_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      cnt_q      <= cnt_d;
      bus_idle_q <= bus_idle_i;
      sleep_q    <= sleep_d;
    end
  end

  assign core_sleep_o = sleep_q;

  a_no_sleep_in_run: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> state_q != SLP_RUN
  ) else $error("core_sleep_o high while in RUN");

  a_wake_ends_sleep: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wake_any |=> !core_sleep_o
  ) else $error("core_sleep_o high after a wake cause");

endmodule

// File: logic/irq_top.sv
/*
 * Interrupt and sleep unit top level
 * Chains sampler, arbiter and issue stage and runs the WFI
 * sleep controller from the same pending vector
 */
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [`IRQ_NUM-1:0]  irq_i,
  input  logic [`IRQ_NUM-1:0]  mie_i,
  input  logic                 mstatus_mie_i,
  input  irq_pkg::priv_lvl_e   priv_lvl_i,
  input  logic                 wfi_i,
  input  logic                 bus_idle_i,
  input  logic                 debug_req_i,
  input  logic                 nmi_i,
  output logic [`IRQ_NUM-1:0]  mip_o,
  output logic                 irq_ack_o,
  output logic [`IRQ_ID_W-1:0] irq_id_o,
  output logic                 core_sleep_o
);

  import irq_pkg::*;

  irq_pend_t pend;
  irq_req_t  req;

  // ------------------------------------------------------------------
  // Interrupt pipeline
  // ------------------------------------------------------------------
  irq_sampler u_irq_sampler (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .irq_i  (irq_i),
    .mie_i  (mie_i),
    .pend_o (pend)
  );

  irq_arbiter u_irq_arbiter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .pend_i (pend),
    .req_o  (req)
  );

  irq_issue u_irq_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  // ------------------------------------------------------------------
  // Sleep control
  // ------------------------------------------------------------------
  sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pend_i       (pend),
    .wfi_i        (wfi_i),
    .bus_idle_i   (bus_idle_i),
    .debug_req_i  (debug_req_i),
    .nmi_i        (nmi_i),
    .core_sleep_o (core_sleep_o)
  );

  assign mip_o = pend.mip;

endmodule

// File: tb/irq_checker.sv
/*
 * Checker for the interrupt and sleep unit
 * Rebuilds mip, the priority result, the acknowledge pulse and
 * the WFI sleep state from the port activity and compares
 */
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_checker (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [`IRQ_NUM-1:0]  irq_i,
  input  logic [`IRQ_NUM-1:0]  mie_i,
  input  logic                 mstatus_mie_i,
  input  irq_pkg::priv_lvl_e   priv_lvl_i,
  input  logic                 wfi_i,
  input  logic                 bus_idle_i,
  input  logic                 debug_req_i,
  input  logic                 nmi_i,
  input  logic [`IRQ_NUM-1:0]  mip_i,
  input  logic                 irq_ack_i,
  input  logic [`IRQ_ID_W-1:0] irq_id_i,
  input  logic                 core_sleep_i,
  output int                   error_cnt_o,
  output int                   check_cnt_o,
  output int                   ack_cnt_o,
  output int                   sleep_cnt_o
);

  import irq_pkg::*;
  import sleep_pkg::*;

  int                   error_cnt;
  int                   check_cnt;
  int                   ack_cnt;
  int                   sleep_cnt;
  logic [`IRQ_NUM-1:0]  exp_mip;
  logic [`IRQ_NUM-1:0]  pend_en;
  logic                 exp_valid;
  logic [`IRQ_ID_W-1:0] exp_win;
  logic                 exp_ack;
  logic [`IRQ_ID_W-1:0] exp_id;
  sleep_state_e         exp_state;
  int unsigned          edges_in_wait;
  logic                 idle_prev;
  logic                 exp_sleep;
  logic                 wake;
  logic                 glob_en;

  assign error_cnt_o = error_cnt;
  assign check_cnt_o = check_cnt;
  assign ack_cnt_o   = ack_cnt;
  assign sleep_cnt_o = sleep_cnt;

  // Search from the top: 31 down to 16, then 11, 3 and 7
  function automatic logic [`IRQ_ID_W:0] pick_winner(input logic [`IRQ_NUM-1:0] pend);
    for (int i = `IRQ_NUM - 1; i >= 16; i--) begin
      if (pend[i]) begin
        return {1'b1, i[`IRQ_ID_W-1:0]};
      end
    end
    if (pend[11]) begin
      return {1'b1, 5'd11};
    end
    if (pend[3]) begin
      return {1'b1, 5'd3};
    end
    if (pend[7]) begin
      return {1'b1, 5'd7};
    end
    return '0;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  initial begin
    error_cnt = 0;
    check_cnt = 0;
    ack_cnt   = 0;
    sleep_cnt = 0;
  end

  // ------------------------------------------------------------------
  // Compare the outputs of the last edge, then advance the model
  // ------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_mip       = '0;
      exp_valid     = 1'b0;
      exp_win       = '0;
      exp_ack       = 1'b0;
      exp_id        = '0;
      exp_state     = SLP_RUN;
      edges_in_wait = 0;
      idle_prev     = 1'b0;
      exp_sleep     = 1'b0;
    end else begin
      compare_value("mip_o", mip_i, exp_mip);
      compare_value("irq_ack_o", irq_ack_i, exp_ack);
      compare_value("irq_id_o", irq_id_i, exp_id);
      compare_value("core_sleep_o", core_sleep_i, exp_sleep);
      if (irq_ack_i) begin
        ack_cnt++;
      end
      if (core_sleep_i) begin
        sleep_cnt++;
      end

      pend_en = exp_mip & mie_i;
      wake    = (|pend_en) || debug_req_i || nmi_i;
      glob_en = (priv_lvl_i == PRIV_U) || (priv_lvl_i == PRIV_M && mstatus_mie_i);

      // Issue stage works on the arbiter result of the previous edge
      exp_ack              = exp_valid && glob_en && !exp_ack;
      exp_id               = exp_win;
      {exp_valid, exp_win} = pick_winner(pend_en);
      exp_mip              = irq_i & `IRQ_VALID_MASK;

      case (exp_state)
        SLP_RUN: begin
          if (wfi_i && !wake) begin
            exp_state     = SLP_WAIT;
            edges_in_wait = 0;
          end
        end
        SLP_WAIT: begin
          // Edges seen since the strobe, this one included
          edges_in_wait++;
          if (wake) begin
            exp_state = SLP_RUN;
          end else if (edges_in_wait >= `WFI_SLEEP_DELAY && bus_idle_i && idle_prev) begin
            exp_state = SLP_SLEEP;
            exp_sleep = 1'b1;
          end
        end
        default: begin
          if (wake) begin
            exp_state = SLP_RUN;
            exp_sleep = 1'b0;
          end
        end
      endcase
      idle_prev = bus_idle_i;
    end
  end

endmodule

// File: tb/tb_irq_top.sv
/*
 * Testbench top for the interrupt and sleep unit
 * Clock and reset, a stimulus table applied in a loop,
 * the checker instance, a cycle limit and the result line
 */
`timescale 1ns/1ps
`include "irq_consts.svh"

module tb_irq_top;

  import irq_pkg::*;

  localparam int num_rows     = 27;
  localparam int seed         = 94564;
  localparam int reset_cycles = 4;

  // One table row, held for hold cycles; wfi only in its first cycle
  typedef struct packed {
    logic [`IRQ_NUM-1:0] irq;
    logic [`IRQ_NUM-1:0] mie;
    logic                mstatus_mie;
    priv_lvl_e           priv;
    logic                wfi;
    logic                bus_idle;
    logic                debug;
    logic                nmi;
    logic                rnd;
    logic [7:0]          hold;
  } stim_row_t;

  logic                 clk;
  logic                 rst_n;
  logic [`IRQ_NUM-1:0]  irq;
  logic [`IRQ_NUM-1:0]  mie;
  logic                 mstatus_mie;
  priv_lvl_e            priv_lvl;
  logic                 wfi;
  logic                 bus_idle;
  logic                 debug_req;
  logic                 nmi;
  logic [`IRQ_NUM-1:0]  mip;
  logic                 irq_ack;
  logic [`IRQ_ID_W-1:0] irq_id;
  logic                 core_sleep;
  int                   error_cnt;
  int                   check_cnt;
  int                   ack_cnt;
  int                   sleep_cnt;
  int unsigned          cycle_cnt;
  int unsigned          cycle_limit;
  stim_row_t            stim_table [num_rows];

  irq_top u_irq_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .irq_i         (irq),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .priv_lvl_i    (priv_lvl),
    .wfi_i         (wfi),
    .bus_idle_i    (bus_idle),
    .debug_req_i   (debug_req),
    .nmi_i         (nmi),
    .mip_o         (mip),
    .irq_ack_o     (irq_ack),
    .irq_id_o      (irq_id),
    .core_sleep_o  (core_sleep)
  );

  irq_checker u_irq_checker (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .irq_i         (irq),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .priv_lvl_i    (priv_lvl),
    .wfi_i         (wfi),
    .bus_idle_i    (bus_idle),
    .debug_req_i   (debug_req),
    .nmi_i         (nmi),
    .mip_i         (mip),
    .irq_ack_i     (irq_ack),
    .irq_id_i      (irq_id),
    .core_sleep_i  (core_sleep),
    .error_cnt_o   (error_cnt),
    .check_cnt_o   (check_cnt),
    .ack_cnt_o     (ack_cnt),
    .sleep_cnt_o   (sleep_cnt)
  );

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  // Run limit, set from the table before reset is released
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic stim_row_t make_row(input logic [31:0] irq_v, input logic [31:0] mie_v,
                                         input logic mmie, input priv_lvl_e priv,
                                         input logic wfi_v, input logic idle,
                                         input logic dbg, input logic nmi_v,
                                         input logic rnd, input logic [7:0] hold);
    return '{irq_v, mie_v, mmie, priv, wfi_v, idle, dbg, nmi_v, rnd, hold};
  endfunction

  // ------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------
  task automatic fill_table();
    // Columns: irq, mie, mstatus_mie, priv, wfi, bus_idle, debug, nmi, random, hold
    stim_table[0]  = make_row(32'h0, 32'h0, 0, PRIV_M, 0, 1, 0, 0, 0, 4);
    // Lines 7 and 3 together, 3 wins
    stim_table[1]  = make_row(32'h0000_0088, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 6);
    stim_table[2]  = make_row(32'h0000_0888, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 5);
    stim_table[3]  = make_row(32'h8001_0888, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 5);
    stim_table[4]  = make_row(32'h0003_0000, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 4);
    // Global enable off in M mode, then mie cleared
    stim_table[5]  = make_row(32'h0000_0088, '1, 0, PRIV_M, 0, 1, 0, 0, 0, 6);
    stim_table[6]  = make_row(32'h0000_0888, 32'h0, 1, PRIV_M, 0, 1, 0, 0, 0, 5);
    stim_table[7]  = make_row(32'h0000_0080, '1, 0, PRIV_U, 0, 1, 0, 0, 0, 6);
    // Reserved lines only
    stim_table[8]  = make_row(32'h0000_f777, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 4);
    stim_table[9]  = make_row(32'h0, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 3);
    // WFI with idle bus, then a debug wake
    stim_table[10] = make_row(32'h0, '1, 1, PRIV_M, 1, 1, 0, 0, 0, 6);
    stim_table[11] = make_row(32'h0, '1, 1, PRIV_M, 0, 1, 1, 0, 0, 3);
    stim_table[12] = make_row(32'h0, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 2);
    // WFI with busy bus, sleep only after two idle cycles
    stim_table[13] = make_row(32'h0, '1, 1, PRIV_M, 1, 0, 0, 0, 0, 5);
    stim_table[14] = make_row(32'h0, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 5);
    stim_table[15] = make_row(32'h0, '1, 1, PRIV_M, 0, 1, 0, 1, 0, 3);
    stim_table[16] = make_row(32'h0, '1, 1, PRIV_M, 0, 1, 0, 0, 0, 2);
    // Wake by an enabled interrupt, then a WFI that is ignored
    stim_table[17] = make_row(32'h0, '1, 1, PRIV_M, 1, 1, 0, 0, 0, 5);
    stim_table[18] = make_row(32'h0000_0800, '1, 0, PRIV_M, 0, 1, 0, 0, 0, 5);
    stim_table[19] = make_row(32'h0000_0800, '1, 0, PRIV_M, 1, 1, 0, 0, 0, 5);
    stim_table[20] = make_row(32'h0, 32'h0, 1, PRIV_M, 0, 1, 0, 0, 0, 3);
    stim_table[21] = make_row(32'h0, 32'h0, 1, PRIV_M, 0, 1, 0, 0, 1, 4);
    stim_table[22] = make_row(32'h0, 32'h0, 1, PRIV_U, 0, 1, 0, 0, 1, 4);
    stim_table[23] = make_row(32'h0, 32'h0, 1, PRIV_M, 1, 1, 0, 0, 1, 4);
    stim_table[24] = make_row(32'h0, 32'h0, 0, PRIV_U, 0, 1, 0, 0, 1, 4);
    stim_table[25] = make_row(32'h0, 32'h0, 0, PRIV_M, 0, 1, 0, 0, 1, 4);
    stim_table[26] = make_row(32'h0, 32'h0, 0, PRIV_M, 0, 1, 0, 0, 0, 4);
  endtask

  task automatic drive_row(input stim_row_t row, input logic first);
    irq         = row.irq;
    mie         = row.mie;
    mstatus_mie = row.mstatus_mie;
    priv_lvl    = row.priv;
    wfi         = row.wfi && first;
    bus_idle    = row.bus_idle;
    debug_req   = row.debug;
    nmi         = row.nmi;
  endtask

  initial begin
    stim_row_t row;
    logic      activity_ok;

    rst_n       = 1'b0;
    irq         = '0;
    mie         = '0;
    mstatus_mie = 1'b0;
    priv_lvl    = PRIV_M;
    wfi         = 1'b0;
    bus_idle    = 1'b1;
    debug_req   = 1'b0;
    nmi         = 1'b0;
    cycle_cnt   = 0;
    void'($urandom(seed));

    fill_table();
    cycle_limit = 50;
    for (int r = 0; r < num_rows; r++) begin
      cycle_limit = cycle_limit + stim_table[r].hold;
    end

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < num_rows; r++) begin
      row = stim_table[r];
      if (row.rnd) begin
        row.irq = $urandom();
        row.mie = $urandom();
      end
      for (int h = 0; h < row.hold; h++) begin
        @(negedge clk);
        drive_row(row, h == 0);
      end
    end
    repeat (3) @(negedge clk);

    activity_ok = (ack_cnt > 0) && (sleep_cnt > 0);
    if (!activity_ok) begin
      $display("No acknowledge or no core sleep was seen during the run");
    end
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0 && activity_ok) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+include
logic/irq_pkg.sv
logic/sleep_pkg.sv
logic/irq_sampler.sv
logic/irq_arbiter.sv
logic/irq_issue.sv
logic/sleep_ctrl.sv
logic/irq_top.sv
tb/irq_checker.sv
tb/tb_irq_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the interrupt and sleep unit testbench with Verilator and run it.
# The run fails if a step returns an error or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
fail_msg="Simulation failed"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_irq_top -o sim_tb_irq_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_irq_top > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "Simulation binary returned status $status"
  exit 1
fi

if grep -q "$fail_msg" "$log_file"; then
  exit 1
fi

exit 0
